// ==== Bender.yml ====
package:
  name: perf_monitor

sources:
  - perf_pkg.sv
  - csr_pkg.sv
  - perf_event_counters.sv
  - perf_sample_timer.sv
  - perf_control_fsm.sv
  - perf_snapshot_regs.sv
  - perf_monitor.sv
  - target: test
    files:
      - perf_monitor_tb.sv

// ==== csr_pkg.sv ====
// *************************************************************************
// Register port definitions for the performance monitor. Describes the
// host request bundle, the write addresses, the read address split into
// counter index and half, and the two ways a write data word is decoded.
// *************************************************************************

package csr_pkg;

	localparam int CSR_ADDR_WIDTH = 6;
	localparam int CSR_DATA_WIDTH = 32;

	// Write addresses
	localparam logic [CSR_ADDR_WIDTH-1:0] CTRL_ADDR = 6'd0;
	localparam logic [CSR_ADDR_WIDTH-1:0] INTERVAL_ADDR = 6'd1;

	// Strobes are high for a single cycle
	typedef struct packed {
		logic                      write;
		logic                      read;
		logic [CSR_ADDR_WIDTH-1:0] addr;
		logic [CSR_DATA_WIDTH-1:0] wdata;
	} csr_req_t;

	// A read address picks a counter and then its low or high word
	typedef struct packed {
		logic [CSR_ADDR_WIDTH-2:0] index;
		logic                      high;
	} csr_rd_addr_t;

	typedef struct packed {
		logic [27:0] reserved;
		logic        snapshot;
		logic        clear;
		logic        stop;
		logic        start;
	} csr_ctrl_t;

	// Control fields at CTRL_ADDR, sample interval in cycles at INTERVAL_ADDR
	typedef union packed {
		csr_ctrl_t                 ctrl;
		logic [CSR_DATA_WIDTH-1:0] interval;
	} csr_wdata_u;

endpackage

// ==== perf_control_fsm.sv ====
// *************************************************************************
// Control FSM of the performance monitor. Decodes host writes into run,
// clear and snapshot actions and the sampling interval. A snapshot holds
// the FSM in SNAPSHOT for one cycle, after which it returns to the run
// state it left. Timer expiry also requests a snapshot.
// *************************************************************************

`timescale 1ns/1ps

module perf_control_fsm import csr_pkg::*; (
	input  logic                      clk,
	input  logic                      reset,
	input  csr_req_t                  csr_req,
	input  logic                      expire,
	output logic                      count_enable,
	output logic                      clear_pulse,
	output logic                      snapshot_pulse,
	output logic                      sample_done,
	output logic                      timer_load,
	output logic [CSR_DATA_WIDTH-1:0] interval
);

	typedef enum logic [1:0] {STOPPED, RUNNING, SNAPSHOT} state_e;

	state_e     state;
	state_e     state_next;
	logic       resume_run;
	logic       snap_pend;
	logic       run_now;
	logic       run_next;
	logic       take_snap;
	logic       ctrl_wr;
	logic       interval_wr;
	csr_wdata_u wdata;

	assign wdata       = csr_req.wdata;
	assign ctrl_wr     = csr_req.write && (csr_req.addr == CTRL_ADDR);
	assign interval_wr = csr_req.write && (csr_req.addr == INTERVAL_ADDR);

	// SNAPSHOT remembers whether it interrupted RUNNING
	assign run_now = (state == SNAPSHOT) ? resume_run : (state == RUNNING);

	always_comb
	begin
		run_next = run_now;
		// Start and stop are ignored in a write that also clears
		if (ctrl_wr && !wdata.ctrl.clear)
		begin
			if (wdata.ctrl.stop)
				run_next = 1'b0;
			else if (wdata.ctrl.start)
				run_next = 1'b1;
		end

		take_snap = (snap_pend || expire) && (state != SNAPSHOT);
		if (take_snap)
			state_next = SNAPSHOT;
		else if (run_next)
			state_next = RUNNING;
		else
			state_next = STOPPED;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state       <= STOPPED;
			resume_run  <= 1'b0;
			snap_pend   <= 1'b0;
			clear_pulse <= 1'b0;
			timer_load  <= 1'b0;
			interval    <= '0;
		end
		else
		begin
			state       <= state_next;
			resume_run  <= run_next;
			// Host requests wait one cycle here, timer requests only if SNAPSHOT is busy
			snap_pend   <= (ctrl_wr && wdata.ctrl.snapshot) || ((snap_pend || expire) && !take_snap);
			clear_pulse <= ctrl_wr && wdata.ctrl.clear;
			timer_load  <= interval_wr;
			if (interval_wr)
				interval <= wdata.interval;
		end
	end

	assign count_enable   = run_now;
	assign snapshot_pulse = (state == SNAPSHOT);
	assign sample_done    = snapshot_pulse;

	a_snapshot_single: assert property (@(posedge clk) disable iff (reset)
		snapshot_pulse |=> !snapshot_pulse);

endmodule

// ==== perf_event_counters.sv ====
// *************************************************************************
// Counter bank of the performance monitor. Keeps one count per event,
// adds one for each single-cycle event and the number of set bits for
// each strand mask. Counting runs while count_enable is high and a clear
// pulse zeroes the whole bank. Counts wrap at COUNTER_WIDTH bits.
// *************************************************************************

`timescale 1ns/1ps

module perf_event_counters import perf_pkg::*; #(
	parameter int unsigned COUNTER_WIDTH = DEFAULT_COUNTER_WIDTH
) (
	input  logic                     clk,
	input  logic                     reset,
	input  perf_events_t             events,
	input  logic                     count_enable,
	input  logic                     clear_pulse,
	output logic [COUNTER_WIDTH-1:0] counts [NUM_COUNTERS]
);

	// Amount each counter advances by this cycle
	logic [2:0] incr [NUM_COUNTERS];

	function automatic logic [2:0] strand_count(input logic [STRAND_COUNT-1:0] mask);
		logic [2:0] total;
		total = '0;
		for (int i = 0; i < STRAND_COUNT; i++)
			total = total + 3'(mask[i]);
		return total;
	endfunction

	always_comb
	begin
		incr[CNT_L2_HIT]              = {2'b00, events.l2_hit};
		incr[CNT_L2_MISS]             = {2'b00, events.l2_miss};
		incr[CNT_L1D_HIT]             = {2'b00, events.l1d_hit};
		incr[CNT_L1D_MISS]            = {2'b00, events.l1d_miss};
		incr[CNT_L1D_COLLIDED_LOAD]   = {2'b00, events.l1d_collided_load};
		incr[CNT_L1I_HIT]             = {2'b00, events.l1i_hit};
		incr[CNT_L1I_MISS]            = {2'b00, events.l1i_miss};
		incr[CNT_L1I_COLLIDED_LOAD]   = {2'b00, events.l1i_collided_load};
		incr[CNT_MISPREDICTED_BRANCH] = {2'b00, events.mispredicted_branch};
		incr[CNT_STORE]               = {2'b00, events.store};
		incr[CNT_INSTRUCTION_ISSUE]   = {2'b00, events.instruction_issue};
		incr[CNT_INSTRUCTION_RETIRE]  = {2'b00, events.instruction_retire};
		incr[CNT_DRAM_PAGE_MISS]      = {2'b00, events.dram_page_miss};
		incr[CNT_DRAM_PAGE_HIT]       = {2'b00, events.dram_page_hit};

		// Wait events count strand-cycles, so several strands may wait at once
		incr[CNT_RAW_WAIT]            = strand_count(events.raw_wait);
		incr[CNT_DCACHE_WAIT]         = strand_count(events.dcache_wait);
		incr[CNT_ICACHE_WAIT]         = strand_count(events.icache_wait);
	end

	// Clear wins over counting in the same cycle
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_COUNTERS; i++)
				counts[i] <= '0;
		end
		else if (clear_pulse)
		begin
			for (int i = 0; i < NUM_COUNTERS; i++)
				counts[i] <= '0;
		end
		else if (count_enable)
		begin
			for (int i = 0; i < NUM_COUNTERS; i++)
				counts[i] <= counts[i] + COUNTER_WIDTH'(incr[i]);
		end
	end

	// The control FSM keeps the run state unchanged in the cycle it clears
	a_clear_apart_from_start: assert property (@(posedge clk) disable iff (reset)
		$rose(clear_pulse) |-> !$rose(count_enable));

endmodule

// ==== perf_monitor.sv ====
// *************************************************************************
// Top level of the performance monitor. Events enter as one bundle and
// the host drives the register port. Counts are read back only from the
// snapshot, in 32-bit halves. COUNTER_WIDTH sets the width of the
// counter bank and of the snapshot store.
// *************************************************************************

`timescale 1ns/1ps

module perf_monitor import perf_pkg::*; import csr_pkg::*; #(
	parameter int unsigned COUNTER_WIDTH = DEFAULT_COUNTER_WIDTH
) (
	input  logic                      clk,
	input  logic                      reset,
	input  perf_events_t              events,
	input  csr_req_t                  csr_req,
	output logic [CSR_DATA_WIDTH-1:0] rdata,
	output logic                      rvalid,
	output logic                      sample_done
);

	logic                      count_enable;
	logic                      clear_pulse;
	logic                      snapshot_pulse;
	logic                      timer_load;
	logic [CSR_DATA_WIDTH-1:0] interval;
	logic                      expire;
	logic [COUNTER_WIDTH-1:0]  counts [NUM_COUNTERS];

	perf_control_fsm i_control_fsm (
		.clk           (clk),
		.reset         (reset),
		.csr_req       (csr_req),
		.expire        (expire),
		.count_enable  (count_enable),
		.clear_pulse   (clear_pulse),
		.snapshot_pulse(snapshot_pulse),
		.sample_done   (sample_done),
		.timer_load    (timer_load),
		.interval      (interval)
	);

	// The timer only advances while the bank is counting
	perf_sample_timer i_sample_timer (
		.clk     (clk),
		.reset   (reset),
		.run     (count_enable),
		.load    (timer_load),
		.interval(interval),
		.expire  (expire)
	);

	perf_event_counters #(
		.COUNTER_WIDTH(COUNTER_WIDTH)
	) i_event_counters (
		.clk         (clk),
		.reset       (reset),
		.events      (events),
		.count_enable(count_enable),
		.clear_pulse (clear_pulse),
		.counts      (counts)
	);

	perf_snapshot_regs #(
		.COUNTER_WIDTH(COUNTER_WIDTH)
	) i_snapshot_regs (
		.clk           (clk),
		.reset         (reset),
		.counts        (counts),
		.snapshot_pulse(snapshot_pulse),
		.read          (csr_req.read),
		.addr          (csr_req.addr),
		.rdata         (rdata),
		.rvalid        (rvalid)
	);

endmodule

// ==== perf_monitor_tb.sv ====
// *************************************************************************
// Self-checking testbench for the performance monitor. Drives random
// events and host register writes, keeps a cycle model of the counter
// bank, sample timer and snapshot, and checks every read and every
// sample_done pulse against that model. One line is printed per test.
// *************************************************************************

`timescale 1ns/1ps

module perf_monitor_tb import perf_pkg::*, csr_pkg::*;;

	localparam int CW = 48;
	localparam int RUN_CYCLES = 300;
	localparam int CLEAR_CYCLES = 100;
	localparam int INTERVAL = 50;
	localparam int AUTO_SAMPLES = 3;
	// One pass over all 64 read addresses plus drain cycles
	localparam int READ_PASS = 2 * 32 + 4;
	localparam int TIMEOUT_CYCLES = 2 * (8 + 6 * READ_PASS + 120 + RUN_CYCLES
		+ 2 * CLEAR_CYCLES + AUTO_SAMPLES * (INTERVAL + READ_PASS) + 40);

	typedef struct packed {
		logic [CSR_ADDR_WIDTH-1:0] addr;
		logic [CSR_DATA_WIDTH-1:0] data;
	} read_exp_t;

	logic         clk;
	logic         reset;
	perf_events_t events;
	csr_req_t     csr_req;
	logic [31:0]  rdata;
	logic         rvalid;
	logic         sample_done;
	csr_wdata_u   req_word;

	logic [31:0]  lfsr_state;
	logic         random_events;
	int           error_count;
	int           check_count;
	int           cycle_count;
	int           errors_at_start;
	int           tests_passed;
	int           tests_failed;

	// Model of the monitor, advanced on every rising edge
	logic [CW-1:0] m_counts [NUM_COUNTERS];
	logic [CW-1:0] m_snap [NUM_COUNTERS];
	logic          m_run;
	logic          m_clear_due;
	int            m_cap_cnt;
	logic [31:0]   m_tick;
	logic [31:0]   m_interval;
	read_exp_t     exp_q [$];
	read_exp_t     exp_head;

	assign req_word = csr_req.wdata;

	perf_monitor #(
		.COUNTER_WIDTH(CW)
	) i_dut (
		.clk        (clk),
		.reset      (reset),
		.events     (events),
		.csr_req    (csr_req),
		.rdata      (rdata),
		.rvalid     (rvalid),
		.sample_done(sample_done)
	);

	// Right-shift Galois LFSR
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'hB4BC_D35C;
		return s >> 1;
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic int ones(input logic [3:0] mask);
		int n;
		n = 0;
		for (int i = 0; i < 4; i++)
			n += mask[i];
		return n;
	endfunction

	// Single-bit events fill the top 14 bits of the bundle in counter order
	function automatic int event_weight(input perf_events_t ev, input int idx);
		if (idx < CNT_RAW_WAIT)
			return ev[25 - idx];
		if (idx == CNT_RAW_WAIT)
			return ones(ev.raw_wait);
		if (idx == CNT_DCACHE_WAIT)
			return ones(ev.dcache_wait);
		return ones(ev.icache_wait);
	endfunction

	// Low or high word of a snapshot count, zero past the last counter
	function automatic logic [31:0] expected_word(input logic [CSR_ADDR_WIDTH-1:0] addr);
		logic [63:0] wide;
		wide = '0;
		if (addr[5:1] < NUM_COUNTERS)
			wide = 64'(m_snap[addr[5:1]]);
		return addr[0] ? wide[63:32] : wide[31:0];
	endfunction

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_COUNTERS; i++)
			begin
				m_counts[i] = '0;
				m_snap[i] = '0;
			end
			m_run = 1'b0;
			m_clear_due = 1'b0;
			m_cap_cnt = 0;
			m_tick = '0;
			m_interval = '0;
		end
		else
		begin
			// A read sees the snapshot as it was before this edge
			if (csr_req.read)
				exp_q.push_back({csr_req.addr, expected_word(csr_req.addr)});
			if (m_cap_cnt > 0)
			begin
				m_cap_cnt--;
				if (m_cap_cnt == 0)
				begin
					for (int i = 0; i < NUM_COUNTERS; i++)
						m_snap[i] = m_counts[i];
				end
			end
			for (int i = 0; i < NUM_COUNTERS; i++)
			begin
				if (m_clear_due)
					m_counts[i] = '0;
				else if (m_run)
					m_counts[i] = m_counts[i] + CW'(event_weight(events, i));
			end
			// The timer counts cycles in which the bank counts
			if (m_run && m_interval != 0)
			begin
				m_tick++;
				if (m_tick == m_interval)
				begin
					m_tick = '0;
					m_cap_cnt = 2;
				end
			end
			m_clear_due = 1'b0;
			if (csr_req.write && csr_req.addr == CTRL_ADDR)
			begin
				m_clear_due = req_word.ctrl.clear;
				if (req_word.ctrl.stop)
					m_run = 1'b0;
				else if (req_word.ctrl.start)
					m_run = 1'b1;
				if (req_word.ctrl.snapshot)
					m_cap_cnt = 2;
			end
			if (csr_req.write && csr_req.addr == INTERVAL_ADDR)
			begin
				m_interval = req_word.interval;
				m_tick = '0;
			end
		end
	end

	// Outputs are compared at the falling edge, half a cycle after they change
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (sample_done !== (m_cap_cnt == 1))
			begin
				$display("Mismatch at %0t: sample_done is %b, expected %b", $time,
					sample_done, m_cap_cnt == 1);
				error_count++;
			end
			if (rvalid && exp_q.size() == 0)
			begin
				$display("At %0t rvalid went high with no read outstanding", $time);
				error_count++;
			end
			else if (exp_q.size() != 0)
			begin
				exp_head = exp_q.pop_front();
				check_count++;
				if (!rvalid)
				begin
					$display("At %0t rvalid did not follow the read of address %0d", $time,
						exp_head.addr);
					error_count++;
				end
				else if (rdata !== exp_head.data)
				begin
					$display("Mismatch at %0t: address %0d read %h, expected %h", $time,
						exp_head.addr, rdata, exp_head.data);
					error_count++;
				end
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES)
		begin
			$display("Timeout after %0d cycles, the run did not complete", TIMEOUT_CYCLES);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	task automatic drive_cycle(input csr_req_t req);
		logic [31:0] bits;
		@(negedge clk);
		csr_req = req;
		bits = random_events ? random_bits($bits(perf_events_t)) : '0;
		events = bits[$bits(perf_events_t)-1:0];
	endtask

	task automatic idle(input int n);
		repeat (n)
			drive_cycle('0);
	endtask

	task automatic write_reg(input logic [CSR_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
		csr_req_t req;
		req = '0;
		req.write = 1'b1;
		req.addr = addr;
		req.wdata = data;
		drive_cycle(req);
	endtask

	task automatic write_ctrl(input logic start, input logic stop, input logic clear,
		input logic snapshot);
		csr_ctrl_t ctrl;
		ctrl = '0;
		ctrl.start = start;
		ctrl.stop = stop;
		ctrl.clear = clear;
		ctrl.snapshot = snapshot;
		write_reg(CTRL_ADDR, ctrl);
	endtask

	task automatic take_snapshot();
		write_ctrl(1'b0, 1'b0, 1'b0, 1'b1);
		idle(3);
	endtask

	// Bit 0 of halves selects the low words, bit 1 the high words
	task automatic read_range(input int first, input int last, input logic [1:0] halves);
		csr_req_t req;
		for (int i = first; i <= last; i++)
		begin
			for (int h = 0; h < 2; h++)
			begin
				if (halves[h])
				begin
					req = '0;
					req.read = 1'b1;
					req.addr = CSR_ADDR_WIDTH'(2 * i + h);
					drive_cycle(req);
				end
			end
		end
		idle(2);
	endtask

	task automatic wait_sample();
		int waited;
		waited = 0;
		do
		begin
			drive_cycle('0);
			waited++;
		end
		while (!sample_done && waited < 2 * INTERVAL);
		if (!sample_done)
		begin
			$display("sample_done did not pulse within %0d cycles", 2 * INTERVAL);
			error_count++;
		end
	endtask

	task automatic end_test(input string name);
		if (error_count == errors_at_start)
		begin
			tests_passed++;
			$display("Test %s: passed", name);
		end
		else
		begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, error_count - errors_at_start);
		end
		errors_at_start = error_count;
	endtask

	initial
	begin
		lfsr_state = 32'h7b6202da;
		random_events = 1'b0;
		reset = 1'b1;
		events = '0;
		csr_req = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		read_range(0, 31, 2'b11);
		end_test("reset state");

		random_events = 1'b1;
		idle(50);
		take_snapshot();
		read_range(0, NUM_COUNTERS - 1, 2'b11);
		end_test("stopped bank");

		write_ctrl(1'b1, 1'b0, 1'b0, 1'b0);
		idle(RUN_CYCLES);
		write_ctrl(1'b0, 1'b1, 1'b0, 1'b0);
		take_snapshot();
		read_range(0, NUM_COUNTERS - 1, 2'b11);
		end_test("running counts");

		write_ctrl(1'b1, 1'b0, 1'b0, 1'b0);
		idle(CLEAR_CYCLES);
		write_ctrl(1'b0, 1'b0, 1'b1, 1'b0);
		idle(CLEAR_CYCLES);
		write_ctrl(1'b0, 1'b1, 1'b0, 1'b0);
		take_snapshot();
		read_range(0, NUM_COUNTERS - 1, 2'b11);
		end_test("clear");

		// The interval is loaded while stopped, so the first period starts at start
		write_reg(INTERVAL_ADDR, INTERVAL);
		idle(2);
		write_ctrl(1'b1, 1'b0, 1'b0, 1'b0);
		repeat (AUTO_SAMPLES)
		begin
			wait_sample();
			read_range(0, NUM_COUNTERS - 1, 2'b11);
		end
		write_ctrl(1'b0, 1'b1, 1'b0, 1'b0);
		idle(4);
		write_reg(INTERVAL_ADDR, 32'd0);
		end_test("automatic snapshot");

		read_range(NUM_COUNTERS, 31, 2'b11);
		read_range(0, NUM_COUNTERS - 1, 2'b10);
		end_test("out-of-range reads");

		$display("Tests: %0d passed, %0d failed, %0d reads checked, %0d errors",
			tests_passed, tests_failed, check_count, error_count);
		if (error_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== perf_pkg.sv ====
// *************************************************************************
// Definitions for the core performance monitor. Holds the event bundle
// raised by the pipeline, caches and memory controller, the index of
// each counter in the bank and the default counter width. Modules that
// count or store events take this package by wildcard import.
// *************************************************************************

package perf_pkg;

	localparam int NUM_COUNTERS = 17;
	localparam int DEFAULT_COUNTER_WIDTH = 48;

	// Width of the per-strand wait masks
	localparam int STRAND_COUNT = 4;

	// Counter index width, large enough for NUM_COUNTERS
	localparam int COUNTER_INDEX_WIDTH = 5;

	// Events are sampled on every rising clock edge
	typedef struct packed {
		logic                    l2_hit;
		logic                    l2_miss;
		logic                    l1d_hit;
		logic                    l1d_miss;
		logic                    l1d_collided_load;
		logic                    l1i_hit;
		logic                    l1i_miss;
		logic                    l1i_collided_load;
		logic                    mispredicted_branch;
		logic                    store;
		logic                    instruction_issue;
		logic                    instruction_retire;
		logic                    dram_page_miss;
		logic                    dram_page_hit;
		logic [STRAND_COUNT-1:0] raw_wait;
		logic [STRAND_COUNT-1:0] dcache_wait;
		logic [STRAND_COUNT-1:0] icache_wait;
	} perf_events_t;

	// Counter slots in the same order as the event fields
	typedef enum logic [COUNTER_INDEX_WIDTH-1:0] {
		CNT_L2_HIT,
		CNT_L2_MISS,
		CNT_L1D_HIT,
		CNT_L1D_MISS,
		CNT_L1D_COLLIDED_LOAD,
		CNT_L1I_HIT,
		CNT_L1I_MISS,
		CNT_L1I_COLLIDED_LOAD,
		CNT_MISPREDICTED_BRANCH,
		CNT_STORE,
		CNT_INSTRUCTION_ISSUE,
		CNT_INSTRUCTION_RETIRE,
		CNT_DRAM_PAGE_MISS,
		CNT_DRAM_PAGE_HIT,
		CNT_RAW_WAIT,
		CNT_DCACHE_WAIT,
		CNT_ICACHE_WAIT
	} perf_counter_e;

endpackage

// ==== perf_sample_timer.sv ====
// *************************************************************************
// Sampling interval timer. Loads a cycle count from the control FSM and
// counts it down while the monitor runs, raising expire for one cycle
// each time the interval has elapsed. An interval of zero stops it.
// *************************************************************************

`timescale 1ns/1ps

module perf_sample_timer (
	input  logic        clk,
	input  logic        reset,
	input  logic        run,
	input  logic        load,
	input  logic [31:0] interval,
	output logic        expire
);

	logic [31:0] interval_q;
	logic [31:0] remaining;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			interval_q <= '0;
			remaining  <= '0;
			expire     <= 1'b0;
		end
		else
		begin
			expire <= 1'b0;
			if (load)
			begin
				interval_q <= interval;
				remaining  <= interval;
			end
			else if (run && interval_q != '0)
			begin
				// Reload on the last cycle so the period is exactly interval_q
				if (remaining <= 32'd1)
				begin
					expire    <= 1'b1;
					remaining <= interval_q;
				end
				else
					remaining <= remaining - 32'd1;
			end
		end
	end

	a_expire_only_running: assert property (@(posedge clk) disable iff (reset)
		$rose(expire) |-> $past(run));

endmodule

// ==== perf_snapshot_regs.sv ====
// *************************************************************************
// Snapshot store and read port of the performance monitor. Copies every
// counter when snapshot_pulse is high and returns the low or high word
// of one stored count one cycle after a read strobe. Indices past the
// last counter read as zero.
// *************************************************************************

`timescale 1ns/1ps

module perf_snapshot_regs import perf_pkg::*; import csr_pkg::*; #(
	parameter int unsigned COUNTER_WIDTH = DEFAULT_COUNTER_WIDTH
) (
	input  logic                      clk,
	input  logic                      reset,
	input  logic [COUNTER_WIDTH-1:0]  counts [NUM_COUNTERS],
	input  logic                      snapshot_pulse,
	input  logic                      read,
	input  logic [CSR_ADDR_WIDTH-1:0] addr,
	output logic [CSR_DATA_WIDTH-1:0] rdata,
	output logic                      rvalid
);

	localparam int WIDE = 2 * CSR_DATA_WIDTH;

	logic [COUNTER_WIDTH-1:0]  snapshot [NUM_COUNTERS];
	csr_rd_addr_t              rd_addr;
	logic [WIDE-1:0]           selected;
	logic [CSR_DATA_WIDTH-1:0] read_word;

	assign rd_addr = addr;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_COUNTERS; i++)
				snapshot[i] <= '0;
		end
		else if (snapshot_pulse)
		begin
			for (int i = 0; i < NUM_COUNTERS; i++)
				snapshot[i] <= counts[i];
		end
	end

	// The count is zero-extended so the high word of a 48-bit count has 16 bits
	always_comb
	begin
		selected = '0;
		if (rd_addr.index < NUM_COUNTERS)
			selected = WIDE'(snapshot[rd_addr.index]);
		if (rd_addr.high)
			read_word = selected[WIDE-1 -: CSR_DATA_WIDTH];
		else
			read_word = selected[CSR_DATA_WIDTH-1:0];
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			rvalid <= 1'b0;
		else
			rvalid <= read;
	end

	always_ff @(posedge clk)
	begin
		if (read)
			rdata <= read_word;
	end

	a_rvalid_after_read: assert property (@(posedge clk) disable iff (reset)
		rvalid == $past(read));

endmodule

// ==== sources.f ====
perf_pkg.sv
csr_pkg.sv
perf_event_counters.sv
perf_sample_timer.sv
perf_control_fsm.sv
perf_snapshot_regs.sv
perf_monitor.sv
perf_monitor_tb.sv
